// File: all.f
+incdir+common
+incdir+verif
common/rv_pkg.sv
id_stage/regfile.sv
id_stage/immd_gen.sv
id_stage/i_decoder.sv
id_stage/id_stage.sv
verif/tb_id_stage.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module tb_id_stage \
    -Mdir obj_dir -o tb_id_stage > build.log 2>&1 \
    && ./obj_dir/tb_id_stage | tee sim.log \
    || echo "Build or run failed, see build.log"

grep -qx "ALL CHECKS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verif/id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

//////////////////////////////
// Expected control bundle
//////////////////////////////

// Base operation by funct3, funct7 overrides come later
function automatic alu_op_e ref_base_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic ctrl_t ref_ctrl(input instr_t ins);
    ctrl_t      c;
    logic [6:0] opc;
    logic [2:0] f3;
    opc = ins[6:0];
    f3  = ins[14:12];
    c   = '0;                                     // No-op unless listed below
    if (opc == `OPC_OP || opc == `OPC_OP_IMM) begin
        c.reg_write = 1'b1;
        c.alu_src   = (opc == `OPC_OP_IMM);
        c.alu_op    = ref_base_op(f3);
        if (ins[30] && f3 == 3'd5) begin
            c.alu_op = ALU_SRA;                   // Arithmetic shift in both forms
        end
        if (ins[30] && f3 == 3'd0 && opc == `OPC_OP) begin
            c.alu_op = ALU_SUB;                   // Register form only
        end
    end else if (opc == `OPC_LOAD || opc == `OPC_STORE) begin
        c.alu_src    = 1'b1;                      // Address is rs1 plus offset
        c.mem_read   = (opc == `OPC_LOAD);
        c.mem_to_reg = (opc == `OPC_LOAD);
        c.reg_write  = (opc == `OPC_LOAD);
        c.mem_write  = (opc == `OPC_STORE);
        c.data_sign  = (opc == `OPC_LOAD) && !f3[2];
        case (f3[1:0])
            2'd0:    c.data_size = SIZE_BYTE;
            2'd1:    c.data_size = SIZE_HALF;
            default: c.data_size = SIZE_WORD;
        endcase
    end else if (opc == `OPC_BRANCH) begin
        c.alu_op = ALU_SUB;
        c.branch = 1'b1;
    end else if (opc == `OPC_JAL || opc == `OPC_JALR) begin
        c.reg_write = 1'b1;                       // Link address to rd
        c.alu_src   = 1'b1;
        c.jump      = 1'b1;
    end else if (opc == `OPC_LUI || opc == `OPC_AUIPC) begin
        c.reg_write = 1'b1;
        c.alu_src   = 1'b1;
        if (opc == `OPC_LUI) begin
            c.alu_op = ALU_PASS_B;
        end
    end
    return c;
endfunction

//////////////////////////////
// Expected immediate
//////////////////////////////

// Fields packed to the top, then an arithmetic shift does the sign
function automatic word_t ref_immd(input instr_t ins);
    word_t raw;
    int    sh;
    raw = '0;
    sh  = 0;
    case (ins[6:0])
        `OPC_OP_IMM, `OPC_LOAD, `OPC_JALR: begin
            raw = ins;
            sh  = 20;
        end
        `OPC_STORE: begin
            raw = {ins[31:25], ins[11:7], 20'd0};
            sh  = 20;
        end
        `OPC_BRANCH: begin
            raw = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'd0};
            sh  = 19;                             // 13 bit offset
        end
        `OPC_LUI, `OPC_AUIPC: raw = ins & 32'hffff_f000;
        `OPC_JAL: begin
            raw = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'd0};
            sh  = 11;                             // 21 bit offset
        end
        default: raw = '0;
    endcase
    raw = $signed(raw) >>> sh;
    return raw;
endfunction

//////////////////////////////
// Shadow register file
//////////////////////////////

word_t shadow_regs [`NUM_REGS];

task automatic shadow_clear();
    for (int i = 0; i < `NUM_REGS; i++) begin
        shadow_regs[i] = '0;
    end
endtask

task automatic shadow_write(input reg_sel_t sel, input word_t val);
    if (sel != '0) begin
        shadow_regs[sel] = val;                   // x0 never changes
    end
endtask

function automatic word_t shadow_read(input reg_sel_t sel);
    return shadow_regs[sel];
endfunction

`endif

// File: verif/tb_id_stage.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_id_stage
    import rv_pkg::*;
();

    // Cycle budget in run order
    // reset, reads, write back, reset again, reads, decode, immd, mem and unknown, random, tail
    localparam int RUN_CYCLES = 5 + 32 + 202 + 6 + 32 + 49 + 2500 + 61 + 300 + 2;
    localparam int MAX_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

    logic     clk;
    logic     reset;
    instr_t   instr;
    logic     reg_write;
    reg_sel_t rd_select;
    word_t    rd_data;
    word_t    immd;
    word_t    data1;
    word_t    data2;
    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    ctrl_t    ctrl;

    int err_count;
    int check_count;
    int cycle_count;

    `include "id_ref.svh"

    id_stage uut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .reg_write (reg_write),
        .rd_select (rd_select),
        .rd_data   (rd_data),
        .immd      (immd),
        .data1     (data1),
        .data2     (data2),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .ctrl      (ctrl)
    );

    always #5 clk = ~clk;            // 10 ns period

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_ctrl(input ctrl_t exp, input ctrl_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: ctrl expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t exp, input reg_sel_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // Compare 1 ns before each edge then mirror the write that edge will do
    always begin
        @(posedge clk);
        #9;
        if (!reset) begin
            check_ctrl(ref_ctrl(instr), ctrl);
            check_word("immd", ref_immd(instr), immd);
            check_sel("rd", instr[11:7], rd);
            check_sel("rs1", instr[19:15], rs1);
            check_sel("rs2", instr[24:20], rs2);
            check_word("data1", shadow_read(instr[19:15]), data1);   // Old value this cycle
            check_word("data2", shadow_read(instr[24:20]), data2);
            if (reg_write) begin
                shadow_write(rd_select, rd_data);
            end
        end else begin
            shadow_clear();                  // Coming edge clears the array
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, stimulus never finished", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic drive(input instr_t ins, input logic we, input reg_sel_t sel, input word_t val);
        @(posedge clk);
        #1;                          // Clear of the edge
        instr     = ins;
        reg_write = we;
        rd_select = sel;
        rd_data   = val;
    endtask

    // Reset pulse starting after the next edge
    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    function automatic reg_sel_t rand_sel();
        return reg_sel_t'($urandom_range(31, 0));
    endfunction

    // R format word with funct3 and funct7 zero
    function automatic instr_t op_instr(input reg_sel_t a, input reg_sel_t b, input reg_sel_t d);
        return {7'b0, b, a, 3'b0, d, `OPC_OP};
    endfunction

    function automatic logic [6:0] known_opc(input int k);
        case (k)
            0:       return `OPC_LUI;
            1:       return `OPC_AUIPC;
            2:       return `OPC_JAL;
            3:       return `OPC_JALR;
            4:       return `OPC_BRANCH;
            5:       return `OPC_LOAD;
            6:       return `OPC_STORE;
            7:       return `OPC_OP_IMM;
            default: return `OPC_OP;
        endcase
    endfunction

    function automatic logic is_known(input logic [6:0] opc);
        for (int k = 0; k < 9; k++) begin
            if (known_opc(k) == opc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Random word with memory funct3 kept to legal sizes
    function automatic instr_t rand_instr(input logic [6:0] opc);
        instr_t      w;
        int unsigned pick;
        w      = $urandom;
        w[6:0] = opc;
        pick   = $urandom_range(4, 0);
        if (opc == `OPC_LOAD) begin
            w[14:12] = (pick > 2) ? 3'(pick + 1) : 3'(pick);   // 0 1 2 4 5
        end else if (opc == `OPC_STORE) begin
            w[14:12] = 3'(pick % 3);
        end
        return w;
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        instr_t     ins;
        reg_sel_t   sel;
        logic [6:0] opc;
        void'($urandom(32'hf83733c1));
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        reg_write   = 1'b0;
        rd_select   = '0;
        rd_data     = '0;
        err_count   = 0;
        check_count = 0;
        cycle_count = 0;
        shadow_clear();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Every register reads zero after reset
        for (int i = 0; i < `NUM_REGS; i++) begin
            drive(op_instr(reg_sel_t'(i), reg_sel_t'(31 - i), '0), 1'b0, '0, '0);
        end

        // Write back then read in the write cycle and the one after
        for (int n = 0; n < 100; n++) begin
            sel = rand_sel();
            ins = op_instr(sel, rand_sel(), sel);
            drive(ins, 1'b1, sel, word_t'($urandom));
            drive(ins, 1'b0, '0, '0);
        end
        drive(op_instr('0, '0, '0), 1'b1, '0, 32'hdead_beef);   // x0 stays zero
        drive(op_instr('0, '0, '0), 1'b0, '0, '0);

        // Reset again with the registers full and read all of them back
        apply_reset(5);
        for (int i = 0; i < `NUM_REGS; i++) begin
            drive(op_instr(reg_sel_t'(i), reg_sel_t'(31 - i), '0), 1'b0, '0, '0);
        end

        // Decode of all funct3 and funct7 variants of OP and OP_IMM
        for (int f = 0; f < 8; f++) begin
            for (int a = 0; a < 2; a++) begin
                drive({1'b0, a[0], 5'b0, rand_sel(), rand_sel(), f[2:0], rand_sel(), `OPC_OP},
                      1'b0, '0, '0);
                drive({1'b0, a[0], 5'b0, rand_sel(), rand_sel(), f[2:0], rand_sel(), `OPC_OP_IMM},
                      1'b0, '0, '0);
            end
        end
        for (int k = 0; k < 9; k++) begin
            drive(rand_instr(known_opc(k)), 1'b0, '0, '0);
        end
        for (int f = 0; f < 8; f++) begin
            ins        = rand_instr(`OPC_BRANCH);
            ins[14:12] = f[2:0];
            drive(ins, 1'b0, '0, '0);
        end

        // Immediates per format with alternating sign
        for (int n = 0; n < 500; n++) begin
            for (int f = 0; f < 5; f++) begin
                case (f)
                    0:       opc = (n % 3 == 0) ? `OPC_LOAD :
                                   (n % 3 == 1) ? `OPC_JALR : `OPC_OP_IMM;
                    1:       opc = `OPC_STORE;
                    2:       opc = `OPC_BRANCH;
                    3:       opc = n[1] ? `OPC_LUI : `OPC_AUIPC;
                    default: opc = `OPC_JAL;
                endcase
                ins     = rand_instr(opc);
                ins[31] = n[0];
                drive(ins, 1'b0, '0, '0);
            end
        end

        // Load and store sizes then no-op opcodes
        for (int f = 0; f < 8; f++) begin
            if (f != 3 && f < 6) begin
                ins        = rand_instr(`OPC_LOAD);
                ins[14:12] = f[2:0];
                drive(ins, 1'b0, '0, '0);
            end
        end
        for (int f = 0; f < 3; f++) begin
            ins        = rand_instr(`OPC_STORE);
            ins[14:12] = f[2:0];
            drive(ins, 1'b0, '0, '0);
        end
        drive(32'h0000_000f, 1'b0, '0, '0);     // FENCE
        drive(32'h0000_0073, 1'b0, '0, '0);     // ECALL
        drive(32'h0010_0073, 1'b0, '0, '0);     // EBREAK
        for (int n = 0; n < 50; n++) begin
            ins = $urandom;
            while (is_known(ins[6:0])) begin
                ins = $urandom;
            end
            drive(ins, 1'b0, '0, '0);
        end

        // Mixed decode and write back
        for (int n = 0; n < 300; n++) begin
            drive(rand_instr(known_opc($urandom_range(8, 0))), $urandom_range(1, 0) == 1,
                  rand_sel(), word_t'($urandom));
        end

        drive('0, 1'b0, '0, '0);
        @(posedge clk);
        if (check_count == 0) begin
            $display("No compares ran, the compare process never fired");
            err_count++;
        end
        $display("Run complete: %0d compares, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: id_stage/id_stage.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module id_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  instr_t   instr,       // Word from fetch, held during stalls

    // Write back from the last stage
    input  logic     reg_write,   // Level, sampled on the rising edge
    input  reg_sel_t rd_select,   // Destination register
    input  word_t    rd_data,     // Value to store

    output word_t    immd,        // Sign extended immediate
    output word_t    data1,       // Register at rs1
    output word_t    data2,       // Register at rs2
    output reg_sel_t rd,
    output reg_sel_t rs1,
    output reg_sel_t rs2,
    output ctrl_t    ctrl         // Decoded control bundle
);

    // Source selects go both to the read ports and out of the stage
    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;

    assign rs1 = rs1_sel;
    assign rs2 = rs2_sel;

    //////////////////////////////
    // Register file
    //////////////////////////////

    regfile registerfile (
        .clk      (clk),
        .reset    (reset),
        // Read side, fully combinational
        .rs1      (rs1_sel),
        .rs1_data (data1),
        .rs2      (rs2_sel),
        .rs2_data (data2),
        // Write back port
        .w_ctrl   (reg_write),
        .w_sel    (rd_select),
        .w_data   (rd_data)
    );

    //////////////////////////////
    // Immediate and decode
    //////////////////////////////

    immd_gen immediategenerator (
        .instr    (instr),
        .immd_out (immd)
    );

    i_decoder instructiondecoder (
        .instr (instr),
        .rs1   (rs1_sel),
        .rs2   (rs2_sel),
        .rd    (rd),
        .ctrl  (ctrl)           // alu_op travels in here
    );

endmodule

// File: id_stage/i_decoder.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module i_decoder
    import rv_pkg::*;
(
    input  instr_t   instr,
    output reg_sel_t rs1,        // Source select A
    output reg_sel_t rs2,        // Source select B
    output reg_sel_t rd,         // Destination select
    output ctrl_t    ctrl        // Carries alu_op with the rest
);

    logic [`OPC_WIDTH-1:0] opcode;
    logic [`F3_WIDTH-1:0]  funct3;
    logic [`F7_WIDTH-1:0]  funct7;

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // funct3 to ALU op for OP and OP_IMM
    // alt is funct7[5], SUB only valid for the register form
    function automatic alu_op_e arith_op(
        input logic [`F3_WIDTH-1:0] f3,
        input logic                 alt,
        input logic                 is_reg
    );
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;     // Both forms
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // Control decode
    //////////////////////////////

    always_comb begin
        ctrl = '0;               // Unknown opcodes stay a no-op

        case (opcode)
            // Register to register arithmetic
            `OPC_OP: begin
                ctrl.alu_op    = arith_op(funct3, funct7[5], 1'b1);
                ctrl.reg_write = 1'b1;
            end

            // Immediate arithmetic, ADDI with negative imm stays ADD
            `OPC_OP_IMM: begin
                ctrl.alu_op    = arith_op(funct3, funct7[5], 1'b0);
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end

            // Address is rs1 plus imm
            `OPC_LOAD: begin
                ctrl.alu_op     = ALU_ADD;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.data_size  = data_size_e'(funct3[1:0]);
                ctrl.data_sign  = ~funct3[2];          // LBU and LHU clear it
            end

            `OPC_STORE: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.data_size = data_size_e'(funct3[1:0]);
            end

            // Compare by subtraction, funct3 picks the condition later
            `OPC_BRANCH: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.branch = 1'b1;
            end

            // Link address written to rd
            `OPC_JAL: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.jump      = 1'b1;
            end

            // Target is rs1 plus imm
            `OPC_JALR: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.jump      = 1'b1;
            end

            `OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;          // Immediate straight to rd
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end

            `OPC_AUIPC: begin
                ctrl.alu_op    = ALU_ADD;             // PC plus upper imm
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end

            // FENCE, SYSTEM and anything else
            default: ctrl = '0;
        endcase
    end

endmodule

// File: id_stage/immd_gen.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module immd_gen
    import rv_pkg::*;
(
    input  instr_t instr,
    output word_t  immd_out      // Sign extended from instr[31]
);

    logic [`OPC_WIDTH-1:0] opcode;
    logic                  sign;

    assign opcode = instr[6:0];
    assign sign   = instr[31];   // Every format keeps its sign here

    //////////////////////////////
    // Layout select
    //////////////////////////////

    always_comb begin
        case (opcode)
            // I layout, imm[11:0] in the top twelve bits
            `OPC_OP_IMM,
            `OPC_LOAD,
            `OPC_JALR: begin
                immd_out = {{20{sign}}, instr[31:20]};
            end

            // S layout, split around rd field
            `OPC_STORE: begin
                immd_out = {{20{sign}}, instr[31:25], instr[11:7]};
            end

            // B layout, halfword offset
            `OPC_BRANCH: begin
                immd_out = {{19{sign}}, sign, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            end

            // U layout, low twelve bits zero
            `OPC_LUI,
            `OPC_AUIPC: begin
                immd_out = {instr[31:12], 12'b0};
            end

            // J layout, scrambled twenty bit offset
            `OPC_JAL: begin
                immd_out = {{11{sign}}, sign, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            end

            default: immd_out = '0;      // R format and unknown
        endcase
    end

endmodule

// File: id_stage/regfile.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_sel_t rs1,        // Read port A select
    input  reg_sel_t rs2,        // Read port B select
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     w_ctrl,     // Write enable
    input  reg_sel_t w_sel,      // Write select
    input  word_t    w_data
);

    word_t regs [`NUM_REGS];

    // Synchronous write, x0 never updated
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;          // Whole array cleared
            end
        end else if (w_ctrl && (w_sel != '0)) begin
            regs[w_sel] <= w_data;
        end
    end

    // Reads are asynchronous
    // No bypass, a same cycle read sees the old value
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: common/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    //////////////////////////////
    // Width carrying types
    //////////////////////////////

    typedef logic [`WORD_SIZE-1:0] word_t;     // Register and bus data
    typedef logic [`WORD_SIZE-1:0] instr_t;    // Raw instruction word
    typedef logic [`REG_SEL-1:0]   reg_sel_t;  // Register index

    //////////////////////////////
    // ALU operation select
    //////////////////////////////

    // Encoding is seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10      // Second operand straight through, LUI
    } alu_op_e;

    // Memory access width, same coding as funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } data_size_e;

    //////////////////////////////
    // Control bundle
    //////////////////////////////

    // Everything the later stages need from decode
    typedef struct packed {
        alu_op_e    alu_op;      // Operation for execute
        logic       mem_read;    // Load from data memory
        logic       mem_write;   // Store to data memory
        logic       mem_to_reg;  // Write back comes from memory
        logic       reg_write;   // Instruction has a destination
        logic       alu_src;     // Second ALU operand is immd
        logic       branch;      // Conditional branch
        logic       jump;        // JAL or JALR
        data_size_e data_size;   // Load and store width
        logic       data_sign;   // Sign extend the loaded value
    } ctrl_t;

endpackage

// File: common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data and instruction width
`define WORD_SIZE 32

// Architectural registers, x0 included
`define NUM_REGS 32

// Bits needed to pick one register
`define REG_SEL 5

//////////////////////////////
// RV32I major opcodes
//////////////////////////////

// Upper immediate group
`define OPC_LUI    7'b0110111   // Load upper immediate
`define OPC_AUIPC  7'b0010111   // PC plus upper immediate

// Control transfer
`define OPC_JAL    7'b1101111   // Jump and link, J format
`define OPC_JALR   7'b1100111   // Register indirect jump, I format
`define OPC_BRANCH 7'b1100011   // Conditional branches, B format

// Memory access
`define OPC_LOAD   7'b0000011   // LB LH LW LBU LHU
`define OPC_STORE  7'b0100011   // SB SH SW

// Integer arithmetic
`define OPC_OP_IMM 7'b0010011   // Register and immediate
`define OPC_OP     7'b0110011   // Register and register

// Field positions inside the instruction word
`define OPC_WIDTH  7
`define F3_WIDTH   3
`define F7_WIDTH   7

`endif
